//--- logic/rv_pkg.sv
package rv_pkg;

  // architectural widths
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [6:0]      funct7_t;

  // major opcodes handled by the core
  localparam opcode_t op_lui     = 7'b0110111;
  localparam opcode_t op_auipc   = 7'b0010111;
  localparam opcode_t op_reg_imm = 7'b0010011;
  localparam opcode_t op_reg_reg = 7'b0110011;
  localparam opcode_t op_branch  = 7'b1100011;
  localparam opcode_t op_environ = 7'b1110011;

  // funct7 forms, alt selects sub and sra/srai
  localparam funct7_t f7_base = 7'b0000000;
  localparam funct7_t f7_alt  = 7'b0100000;

  // funct3 for alu work
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_srl  = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // funct3 for conditional branches
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  // operand a source
  typedef enum logic [1:0] {
    src_a_rs1,
    src_a_pc,
    src_a_zero
  } src_a_t;

  localparam word_t pc_step  = 32'd4;
  localparam word_t reset_pc = 32'd0;

endpackage

//--- logic/cla_adder.sv
`timescale 1ns/100ps

module cla_adder (
  input  rv_pkg::word_t a,
  input  rv_pkg::word_t b,
  input  logic          cin,
  output rv_pkg::word_t sum
);
  import rv_pkg::*;

  word_t g;
  word_t p;
  word_t c;
  logic [xlen/4-1:0] grp_g;
  logic [xlen/4-1:0] grp_p;
  logic [xlen/4:0]   grp_c;

  // per-bit generate and propagate
  assign g = a & b;
  assign p = a ^ b;

  // group generate and propagate over each 4-bit block
  always_comb begin
    for (int k = 0; k < xlen / 4; k++) begin
      grp_p[k] = &p[k*4 +: 4];
      grp_g[k] = 1'b0;
      for (int i = 0; i < 4; i++) begin
        grp_g[k] = g[k*4+i] | (p[k*4+i] & grp_g[k]);
      end
    end
  end

  // block-level lookahead, each block carry expanded from cin
  always_comb begin : block_carry
    logic prod;
    logic acc;
    grp_c[0] = cin;
    for (int k = 1; k <= xlen / 4; k++) begin
      prod = 1'b1;
      acc  = 1'b0;
      for (int j = k - 1; j >= 0; j--) begin
        acc  = acc | (prod & grp_g[j]);
        prod = prod & grp_p[j];
      end
      grp_c[k] = acc | (prod & cin);
    end
  end

  // carries inside each block
  always_comb begin
    for (int k = 0; k < xlen / 4; k++) begin
      c[k*4] = grp_c[k];
      for (int i = 0; i < 3; i++) begin
        c[k*4+i+1] = g[k*4+i] | (p[k*4+i] & c[k*4+i]);
      end
    end
  end

  assign sum = p ^ c;

endmodule

//--- logic/alu.sv
`timescale 1ns/100ps

module alu (
  input  rv_pkg::src_a_t  src_a,
  input  logic            use_imm,
  input  rv_pkg::alu_op_t alu_op,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   pc,
  input  rv_pkg::word_t   imm,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  word_t      op_a;
  word_t      op_b;
  word_t      add_b;
  word_t      sum;
  logic       add_cin;
  logic [4:0] shamt;

  // operand a: rs1, pc for auipc, zero for lui
  always_comb begin
    case (src_a)
      src_a_pc:   op_a = pc;
      src_a_zero: op_a = '0;
      default:    op_a = rs1_data;
    endcase
  end

  assign op_b = use_imm ? imm : rs2_data;

  // subtract as a + ~b + 1
  assign add_cin = (alu_op == alu_sub);
  assign add_b   = add_cin ? ~op_b : op_b;

  // shift amounts above 31 wrap to five bits
  assign shamt = op_b[4:0];

  cla_adder adder_i (
    .a   (op_a),
    .b   (add_b),
    .cin (add_cin),
    .sum (sum)
  );

  always_comb begin
    case (alu_op)
      alu_add,
      alu_sub:    result = sum;
      alu_sll:    result = op_a << shamt;
      alu_slt:    result = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
      alu_sltu:   result = (op_a < op_b) ? word_t'(1) : '0;
      alu_xor:    result = op_a ^ op_b;
      alu_srl:    result = op_a >> shamt;
      alu_sra:    result = word_t'($signed(op_a) >>> shamt);
      alu_or:     result = op_a | op_b;
      alu_and:    result = op_a & op_b;
      alu_pass_b: result = op_b;
      default:    result = '0;
    endcase
  end

endmodule

//--- logic/insn_decoder.sv
`timescale 1ns/100ps

module insn_decoder (
  input  rv_pkg::word_t     insn,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::funct3_t   funct3,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_t   alu_op,
  output rv_pkg::src_a_t    src_a,
  output logic              use_imm,
  output logic              rf_we,
  output logic              branch,
  output logic              halt,
  output logic              illegal
);
  import rv_pkg::*;

  opcode_t opcode;
  funct7_t funct7;
  word_t   imm_i;
  word_t   imm_b;
  word_t   imm_u;
  logic    alt;

  // funct3 and alt form to alu operation
  function automatic alu_op_t op_from_funct3(funct3_t f3, logic alt_form);
    alu_op_t op;
    case (f3)
      f3_add:  op = alt_form ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_srl:  op = alt_form ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  // instruction fields
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];
  assign alt    = (funct7 == f7_alt);

  // immediates, sign extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    imm     = imm_i;
    alu_op  = alu_add;
    src_a   = src_a_rs1;
    use_imm = 1'b0;
    rf_we   = 1'b0;
    branch  = 1'b0;
    halt    = 1'b0;
    illegal = 1'b0;
    case (opcode)
      op_lui: begin
        imm     = imm_u;
        alu_op  = alu_pass_b;
        src_a   = src_a_zero;
        use_imm = 1'b1;
        rf_we   = 1'b1;
      end
      op_auipc: begin
        imm     = imm_u;
        src_a   = src_a_pc;
        use_imm = 1'b1;
        rf_we   = 1'b1;
      end
      op_reg_imm: begin
        use_imm = 1'b1;
        // upper immediate bits only act as funct7 on shifts
        alu_op  = op_from_funct3(funct3, alt && funct3 == f3_srl);
        if (funct3 == f3_sll) begin
          illegal = (funct7 != f7_base);
        end else if (funct3 == f3_srl) begin
          illegal = (funct7 != f7_base) && !alt;
        end
        rf_we = !illegal;
      end
      op_reg_reg: begin
        alu_op  = op_from_funct3(funct3, alt);
        illegal = (funct7 != f7_base) && !(alt && (funct3 == f3_add || funct3 == f3_srl));
        rf_we   = !illegal;
      end
      op_branch: begin
        imm     = imm_b;
        illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
        branch  = !illegal;
      end
      op_environ: begin
        // only ecall, every other field zero
        halt    = (insn[31:7] == '0);
        illegal = !halt;
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);
  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:2**$bits(reg_addr_t)-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 2**$bits(reg_addr_t); i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // reads are combinational, x0 reads zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
  input  logic            clk,
  input  logic            rst,
  input  logic            branch,
  input  logic            halt,
  input  rv_pkg::funct3_t funct3,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  output rv_pkg::word_t   pc
);
  import rv_pkg::*;

  logic  taken;
  word_t pc_next;

  // branch condition from funct3
  always_comb begin
    case (funct3)
      f3_beq:  taken = (rs1_data == rs2_data);
      f3_bne:  taken = (rs1_data != rs2_data);
      f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: taken = (rs1_data < rs2_data);
      f3_bgeu: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // hold on halt, else target or sequential
  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (branch && taken) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + pc_step;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/100ps

module rv_core (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     insn,
  output rv_pkg::word_t     pc,
  output logic              wb_we,
  output rv_pkg::reg_addr_t wb_rd,
  output rv_pkg::word_t     wb_data,
  output logic              halt,
  output logic              illegal
);
  import rv_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  funct3_t   funct3;
  word_t     imm;
  word_t     rs1_data;
  word_t     rs2_data;
  alu_op_t   alu_op;
  src_a_t    src_a;
  logic      use_imm;
  logic      rf_we;
  logic      branch;

  insn_decoder decoder_i (
    .insn    (insn),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (wb_rd),
    .funct3  (funct3),
    .imm     (imm),
    .alu_op  (alu_op),
    .src_a   (src_a),
    .use_imm (use_imm),
    .rf_we   (rf_we),
    .branch  (branch),
    .halt    (halt),
    .illegal (illegal)
  );

  // no writes while in reset
  assign wb_we = rf_we && !rst;

  reg_file reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .we       (wb_we),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu alu_i (
    .src_a    (src_a),
    .use_imm  (use_imm),
    .alu_op   (alu_op),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .imm      (imm),
    .result   (wb_data)
  );

  fetch_unit fetch_i (
    .clk      (clk),
    .rst      (rst),
    .branch   (branch),
    .halt     (halt),
    .funct3   (funct3),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .pc       (pc)
  );

endmodule

//--- bench/rv_core_assert.sv
`timescale 1ns/100ps

module rv_core_assert (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t pc,
  input logic          wb_we,
  input logic          halt,
  input logic          illegal
);
  import rv_pkg::*;

  // fetch addresses stay word aligned
  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc %08h is not word aligned", pc);

  // ecall never writes a register
  halt_no_write: assert property (@(posedge clk) disable iff (rst) halt |-> !wb_we)
    else $error("write strobe raised together with halt");

  // rejected encodings never write either
  illegal_no_write: assert property (@(posedge clk) disable iff (rst) illegal |-> !wb_we)
    else $error("write strobe raised for an illegal instruction");

endmodule

bind rv_core rv_core_assert assert_i (
  .clk     (clk),
  .rst     (rst),
  .pc      (pc),
  .wb_we   (wb_we),
  .halt    (halt),
  .illegal (illegal)
);

//--- bench/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int    fields      = 6;
  localparam int    max_records = 64;
  localparam int    max_cycles  = 200;
  localparam int    reset_limit = 8;
  localparam int    hold_cycles = 3;
  localparam word_t nop_insn    = 32'h00000013;

  logic      clk;
  logic      rst;
  word_t     insn;
  word_t     pc;
  logic      wb_we;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      halt;
  logic      illegal;

  // one record is insn, wb_we, wb_rd, wb_data, next pc, status
  word_t tv [0:max_records*fields-1];
  int    n_records;
  int    n_tests;
  int    n_failed;
  int    n_errors;

  rv_core dut_i (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .wb_we   (wb_we),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .halt    (halt),
    .illegal (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error %s got %08h expected %08h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("error %s got %02h expected %02h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic log_test_result(input string what, input int errs_before);
    n_tests++;
    if (n_errors != errs_before) begin
      n_failed++;
      $display("test %0d %s failed", n_tests, what);
    end else begin
      $display("test %0d %s ok", n_tests, what);
    end
  endtask

  initial begin : main
    int    idx;
    int    base;
    int    waited;
    int    cycles;
    int    errs_before;
    logic  done;
    logic  aborted;
    word_t cur_pc;
    word_t exp_next;
    word_t exp_status;

    rst       = 1'b1;
    insn      = nop_insn;
    n_tests   = 0;
    n_failed  = 0;
    n_errors  = 0;
    n_records = 0;
    done      = 1'b0;
    aborted   = 1'b0;
    cycles    = 0;

    for (int i = 0; i < max_records * fields; i++) begin
      tv[i] = 'x;
    end
    $readmemh("bench/rv_core_tests.hex", tv);
    while (n_records < max_records && !$isunknown(tv[n_records*fields])) begin
      n_records++;
    end
    if (n_records == 0) begin
      $display("no test records could be read from the data file");
      aborted = 1'b1;
      n_failed++;
    end

    // reset, nop presented, no write strobe
    errs_before = n_errors;
    repeat (2) begin
      @(posedge clk);
      #1;
      check_bit("wb_we", wb_we, 1'b0);
    end
    rst    = 1'b0;
    waited = 0;
    while (pc !== reset_pc && waited < reset_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (pc !== reset_pc) begin
      $display("timeout while waiting for pc to reach the reset address");
      aborted = 1'b1;
      n_failed++;
    end
    log_test_result("reset", errs_before);

    // play instruction memory until the halt record has run
    while (!aborted && !done && cycles < max_cycles) begin
      errs_before = n_errors;
      cur_pc      = pc;
      idx         = int'(cur_pc >> 2);
      if ($isunknown(cur_pc) || cur_pc[1:0] != 2'b00 || idx >= n_records) begin
        $display("pc %08h points outside the test program", cur_pc);
        aborted = 1'b1;
        n_failed++;
      end else begin
        base       = idx * fields;
        insn       = tv[base];
        exp_next   = tv[base+4];
        exp_status = tv[base+5];
        @(negedge clk);
        check_bit("wb_we", wb_we, tv[base+1][0]);
        if (tv[base+1][0]) begin
          check_reg("wb_rd", wb_rd, tv[base+2][4:0]);
          check_word("wb_data", wb_data, tv[base+3]);
        end
        check_bit("halt", halt, exp_status[0]);
        check_bit("illegal", illegal, exp_status[1]);
        @(posedge clk);
        #1;
        check_word("pc", pc, exp_next);
        log_test_result($sformatf("pc %08h insn %08h", cur_pc, tv[base]), errs_before);
        done = exp_status[0];
        cycles++;
      end
    end
    if (!aborted && !done) begin
      $display("timeout, no halt after %0d instructions", cycles);
      aborted = 1'b1;
      n_failed++;
    end

    // ecall stays presented, pc must hold at the halt address
    if (!aborted) begin
      errs_before = n_errors;
      repeat (hold_cycles) begin
        @(negedge clk);
        check_bit("halt", halt, 1'b1);
        check_bit("wb_we", wb_we, 1'b0);
        @(posedge clk);
        #1;
        check_word("pc", pc, exp_next);
      end
      log_test_result("halt hold", errs_before);
    end

    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
    if (aborted || n_failed != 0 || n_errors != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

endmodule

//--- bench/rv_core_tests.hex
// insn wb_we wb_rd wb_data next_pc status, one record per word address
// status 1 means halt, 2 means illegal
ffb00093 1 01 fffffffb 00000004 0
7ff00113 1 02 000007ff 00000008 0
fff0a193 1 03 00000001 0000000c 0
0050b213 1 04 00000000 00000010 0
0f014293 1 05 0000070f 00000014 0
80016313 1 06 ffffffff 00000018 0
0ff0f393 1 07 000000fb 0000001c 0
01411413 1 08 7ff00000 00000020 0
0040d493 1 09 0fffffff 00000024 0
4010d513 1 0a fffffffd 00000028 0
00110013 1 00 00000800 0000002c 0 // x0 strobes but keeps zero
002005b3 1 0b 000007ff 00000030 0
12345637 1 0c 12345000 00000034 0
fffff697 1 0d fffff034 00000038 0
00260733 1 0e 123457ff 0000003c 0
001487b3 1 0f 0ffffffa 00000040 0 // carry through every block
40600833 1 10 00000001 00000044 0
408108b3 1 11 801007ff 00000048 0
00511933 1 12 03ff8000 0000004c 0
0070d9b3 1 13 0000001f 00000050 0
4070da33 1 14 ffffffff 00000054 0
0020aab3 1 15 00000001 00000058 0
0020bb33 1 16 00000000 0000005c 0
0060cbb3 1 17 00000004 00000060 0
0082ec33 1 18 7ff0070f 00000064 0
00177cb3 1 19 123457fb 00000068 0
00208463 0 00 00000000 0000006c 0
00209663 0 00 00000000 00000078 0
0020c863 0 00 00000000 00000080 0
00000013 1 00 00000000 00000078 0 // skipped
fe20fce3 0 00 00000000 00000070 0 // backward to 0x70
00000013 1 00 00000000 00000080 0 // skipped
0020d463 0 00 00000000 00000084 0
0020e463 0 00 00000000 00000088 0
00b10463 0 00 00000000 00000090 0
00000013 1 00 00000000 00000090 0 // skipped
00b11463 0 00 00000000 00000094 0
00114463 0 00 00000000 00000098 0
00115463 0 00 00000000 000000a0 0
00000013 1 00 00000000 000000a0 0 // skipped
00116463 0 00 00000000 000000a8 0
00000013 1 00 00000000 000000a8 0 // skipped
00117463 0 00 00000000 000000ac 0
0000a103 0 00 00000000 000000b0 2
00000073 0 00 00000000 000000b0 1

//--- rv_single_cycle.f
logic/rv_pkg.sv
logic/cla_adder.sv
logic/alu.sv
logic/insn_decoder.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/rv_core.sv
bench/rv_core_assert.sv
bench/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_single_cycle

sources:
  - logic/rv_pkg.sv
  - logic/cla_adder.sv
  - logic/alu.sv
  - logic/insn_decoder.sv
  - logic/reg_file.sv
  - logic/fetch_unit.sv
  - logic/rv_core.sv
  - target: test
    files:
      - bench/rv_core_assert.sv
      - bench/rv_core_tb.sv
